// File: sources.f
+incdir+.
rv_pkg.sv
rv_ctrl_if.sv
rv_control.sv
rv_fetch.sv
rv_regfile.sv
rv_imm_gen.sv
rv_execute.sv
rv_data_mem.sv
rv_core.sv
tb_rv_core_sva.sv
tb_rv_core.sv

// File: Makefile
TOP := tb_rv_core

.PHONY: compile run clean

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -f sources.f -o $(TOP)

run: compile
	-./obj_dir/$(TOP) +verilator+error+limit+1000 > sim.log 2>&1
	cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_rv_core.sv
`include "rv_params.svh"
`default_nettype none

module tb_rv_core;

    localparam int RANDOM_WORDS = 2000;

    logic        I_clk;
    logic        rst_n;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        rd_wen;
    logic [3:0]  rd_addr;
    logic [31:0] rd_data;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        illegal;

    // Shadow model state
    logic [31:0] m_regs [`RV_REG_COUNT];
    logic [31:0] m_mem  [`RV_DMEM_WORDS];
    logic [31:0] m_pc;

    // Expected response to the word in flight
    logic        e_wen;
    logic [4:0]  e_rd;
    logic [31:0] e_rd_data;
    logic        e_mem_we;
    logic [31:0] e_mem_addr;
    logic [31:0] e_mem_wdata;
    logic [31:0] e_next_pc;
    logic        e_illegal;

    logic [31:0] setup_q [$];
    logic [31:0] cur_word;
    logic [31:0] jump_base;
    logic [11:0] win_off;
    int          seed;
    int          err_count;
    int          check_count;
    int          timeout_count;
    int          sva_fails;
    bit          pc_ready;

    rv_core u_dut (
        .I_clk     (I_clk),
        .rst_n     (rst_n),
        .pc        (pc),
        .instr     (instr),
        .rd_wen    (rd_wen),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .illegal   (illegal)
    );

    always #5 I_clk = ~I_clk;

    function automatic logic [31:0] rand_below(input logic [31:0] limit);
        logic [31:0] r;
        r = $random(seed);
        return r % limit;
    endfunction

    // Integer ALU result as the ISA defines it
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // x15 is the data base and x14 the jump base, so random rd stays below 14
    task automatic random_word(output logic [31:0] w);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] off;
        r   = $random(seed);
        rd  = 5'(rand_below(14));
        rs1 = 5'(rand_below(16));
        rs2 = 5'(rand_below(16));
        f3  = r[14:12];
        off = {6'd0, r[19:16], 2'b00};
        case (rand_below(16))
            0, 1, 2: begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00;
                w  = {f7, rs2, rs1, f3, rd, 7'b0110011};
            end
            3, 4, 5, 15: begin
                f7 = r[31:25];
                if (f3 == 3'd1)
                    f7 = 7'h00;
                else if (f3 == 3'd5)
                    f7 = r[30] ? 7'h20 : 7'h00;
                w = {f7, r[24:20], rs1, f3, rd, 7'b0010011};
            end
            6:  w = {r[31:12], rd, 7'b0110111};
            7:  w = {r[31:12], rd, 7'b0010111};
            8:  w = {off, 5'd15, 3'b010, rd, 7'b0000011};
            9:  w = {off[11:5], rs2, 5'd15, 3'b010, off[4:0], 7'b0100011};
            10, 11: begin
                // funct3 2 and 3 are reserved for branches
                if (f3[2:1] == 2'b01)
                    f3 = {2'b10, f3[0]};
                w = {r[31], r[30:25], rs2, rs1, f3, r[11:9], 1'b0, r[7], 7'b1100011};
            end
            12: w = {r[31], r[30:22], 1'b0, r[20], r[19:12], rd, 7'b1101111};
            13: w = {r[31:22], 2'b00, 5'd14, 3'b000, rd, 7'b1100111};
            default: begin
                // SYSTEM opcode, or ADD naming a register above x15
                if (r[0])
                    w = {r[31:7], 7'b1110011};
                else
                    w = {7'h00, rs2, 1'b1, rs1[3:0], 3'b000, rd, 7'b0110011};
            end
        endcase
    endtask

    task automatic next_word(output logic [31:0] w);
        if (setup_q.size() > 0)
            w = setup_q.pop_front();
        else
            random_word(w);
    endtask

    task automatic predict(input logic [31:0] w);
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic        taken;
        logic        bad_reg;
        rs1   = w[19:15];
        rs2   = w[24:20];
        f3    = w[14:12];
        e_rd  = w[11:7];
        a     = m_regs[rs1[3:0]];
        b     = m_regs[rs2[3:0]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        e_wen       = 1'b0;
        e_mem_we    = 1'b0;
        e_illegal   = 1'b0;
        e_rd_data   = '0;
        e_mem_addr  = '0;
        e_mem_wdata = '0;
        e_next_pc   = m_pc + 32'd4;
        bad_reg     = 1'b0;
        case (w[6:0])
            7'b0110011: begin
                e_wen     = 1'b1;
                e_rd_data = alu_ref(f3, w[30], a, b);
                bad_reg   = e_rd[4] | rs1[4] | rs2[4];
            end
            7'b0010011: begin
                e_wen     = 1'b1;
                e_rd_data = alu_ref(f3, f3 == 3'd5 && w[30], a, imm_i);
                bad_reg   = e_rd[4] | rs1[4];
            end
            7'b0110111: begin
                e_wen     = 1'b1;
                e_rd_data = {w[31:12], 12'h000};
                bad_reg   = e_rd[4];
            end
            7'b0010111: begin
                e_wen     = 1'b1;
                e_rd_data = m_pc + {w[31:12], 12'h000};
                bad_reg   = e_rd[4];
            end
            7'b0000011: begin
                e_wen      = 1'b1;
                e_mem_addr = a + imm_i;
                e_rd_data  = m_mem[e_mem_addr[9:2]];
                bad_reg    = e_rd[4] | rs1[4];
            end
            7'b0100011: begin
                e_mem_we    = 1'b1;
                e_mem_addr  = a + {{20{w[31]}}, w[31:25], w[11:7]};
                e_mem_wdata = b;
                bad_reg     = rs1[4] | rs2[4];
            end
            7'b1100011: begin
                taken = f3[2] ? (f3[1] ? a < b : $signed(a) < $signed(b)) : a == b;
                if (taken ^ f3[0])
                    e_next_pc = m_pc + imm_b;
                bad_reg = rs1[4] | rs2[4];
            end
            7'b1101111: begin
                e_wen     = 1'b1;
                e_rd_data = m_pc + 32'd4;
                e_next_pc = m_pc + imm_j;
                bad_reg   = e_rd[4];
            end
            7'b1100111: begin
                e_wen     = 1'b1;
                e_rd_data = m_pc + 32'd4;
                e_next_pc = (a + imm_i) & 32'hffff_fffe;
                bad_reg   = e_rd[4] | rs1[4];
            end
            default: e_illegal = 1'b1;
        endcase
        // Illegal words retire as a no-op
        if (bad_reg || e_illegal) begin
            e_illegal = 1'b1;
            e_wen     = 1'b0;
            e_mem_we  = 1'b0;
            e_next_pc = m_pc + 32'd4;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        err_count++;
        $display("ERR %s expected %h actual %h at pc %h", name, expected, actual, m_pc);
    endtask

    task automatic check_outputs();
        check_count++;
        assert (pc === m_pc) else report_mismatch("pc", m_pc, pc);
        assert (illegal === e_illegal)
            else report_mismatch("illegal", 32'(e_illegal), 32'(illegal));
        assert (rd_wen === e_wen) else report_mismatch("rd_wen", 32'(e_wen), 32'(rd_wen));
        assert (mem_we === e_mem_we)
            else report_mismatch("mem_we", 32'(e_mem_we), 32'(mem_we));
        if (e_wen) begin
            assert (rd_addr === e_rd[3:0])
                else report_mismatch("rd_addr", 32'(e_rd[3:0]), 32'(rd_addr));
            assert (rd_data === e_rd_data) else report_mismatch("rd_data", e_rd_data, rd_data);
        end
        if (e_mem_we) begin
            assert (mem_addr === e_mem_addr)
                else report_mismatch("mem_addr", e_mem_addr, mem_addr);
            assert (mem_wdata === e_mem_wdata)
                else report_mismatch("mem_wdata", e_mem_wdata, mem_wdata);
        end
    endtask

    task automatic commit_model();
        if (e_wen && e_rd != 5'd0)
            m_regs[e_rd[3:0]] = e_rd_data;
        if (e_mem_we)
            m_mem[e_mem_addr[9:2]] = e_mem_wdata;
        m_pc = e_next_pc;
    endtask

    task automatic wait_reset_pc(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < 4 && !ok; n++) begin
            @(negedge I_clk);
            ok = pc === `RV_RESET_PC;
        end
    endtask

    initial begin
        int          total;
        logic [31:0] reset_word;
        seed          = 32'h337ce2da;
        err_count     = 0;
        check_count   = 0;
        timeout_count = 0;
        I_clk         = 1'b0;
        rst_n         = 1'b0;
        random_word(reset_word);
        instr         = reset_word;
        m_pc          = `RV_RESET_PC;
        for (int k = 0; k < `RV_REG_COUNT; k++) begin
            m_regs[k] = '0;
        end

        // x15 = 0x100 for the data window, x14 an aligned jump base
        jump_base = $random(seed);
        setup_q.push_back({20'd0, 5'd15, 7'b0110111});
        setup_q.push_back({12'h100, 5'd15, 3'b000, 5'd15, 7'b0010011});
        setup_q.push_back({jump_base[31:12], 5'd14, 7'b0110111});
        // Clear the 16-word window so every load sees a defined word
        for (int k = 0; k < 16; k++) begin
            win_off = 12'(k * 4);
            setup_q.push_back({win_off[11:5], 5'd0, 5'd15, 3'b010, win_off[4:0], 7'b0100011});
        end
        total = setup_q.size() + RANDOM_WORDS;

        // Random words keep arriving while reset is held
        for (int k = 0; k < 15; k++) begin
            @(posedge I_clk);
            random_word(reset_word);
            instr <= reset_word;
        end
        @(posedge I_clk);
        rst_n <= 1'b1;
        next_word(cur_word);
        instr <= cur_word;

        wait_reset_pc(pc_ready);
        if (!pc_ready) begin
            timeout_count++;
            $display("Timeout: pc did not reach the reset value after reset was released");
        end else begin
            for (int i = 0; i < total; i++) begin
                predict(cur_word);
                check_outputs();
                @(posedge I_clk);
                commit_model();
                next_word(cur_word);
                instr <= cur_word;
                @(negedge I_clk);
            end
        end

        sva_fails = u_dut.u_sva.fail_count;
        $display("Checks %0d, value errors %0d, assertion failures %0d, timeouts %0d",
                 check_count, err_count, sva_fails, timeout_count);
        if (err_count == 0 && sva_fails == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_rv_core_sva.sv
`include "rv_params.svh"
`default_nettype none

module rv_core_sva (
    input logic        I_clk,
    input logic        rst_n,
    input logic [31:0] pc,
    input logic        rd_wen,
    input logic        mem_we,
    input logic [31:0] mem_addr,
    input logic        illegal
);

    int fail_count = 0;

    // PC restarts at the reset vector
    reset_pc: assert property (@(posedge I_clk) !rst_n |=> pc == `RV_RESET_PC)
        else begin
            fail_count++;
            $error("pc is not the reset value after a reset cycle");
        end

    // Strobes stay quiet while held in reset, whatever word is fetched
    reset_quiet: assert property (@(posedge I_clk) !rst_n |-> !rd_wen && !mem_we && !illegal)
        else begin
            fail_count++;
            $error("a strobe or illegal is active during reset");
        end

    illegal_no_write: assert property (@(posedge I_clk) disable iff (!rst_n)
        illegal |-> !rd_wen && !mem_we)
        else begin
            fail_count++;
            $error("illegal word caused a register or memory write");
        end

    illegal_next_pc: assert property (@(posedge I_clk) disable iff (!rst_n)
        illegal |=> pc == $past(pc) + 32'd4)
        else begin
            fail_count++;
            $error("pc after an illegal word is not pc plus 4");
        end

    pc_aligned: assert property (@(posedge I_clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("pc is not word aligned");
        end

    store_aligned: assert property (@(posedge I_clk) disable iff (!rst_n)
        mem_we |-> mem_addr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("store address is not word aligned");
        end

endmodule

bind rv_core rv_core_sva u_sva (
    .I_clk    (I_clk),
    .rst_n    (rst_n),
    .pc       (pc),
    .rd_wen   (rd_wen),
    .mem_we   (mem_we),
    .mem_addr (mem_addr),
    .illegal  (illegal)
);

`default_nettype wire

// File: rv_core.sv
`default_nettype none

module rv_core (
    input  logic        I_clk,
    input  logic        rst_n,
    output logic [31:0] pc,
    input  logic [31:0] instr,
    output logic        rd_wen,
    output logic [3:0]  rd_addr,
    output logic [31:0] rd_data,
    output logic        mem_we,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic        illegal
);

    logic [3:0]  rs1_addr;
    logic [3:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm;
    logic [31:0] alu_result;
    logic [31:0] load_data;
    logic [31:0] pc_plus4;
    logic [31:0] dec_instr;

    rv_ctrl_if ctrl_bus ();

    // RV32E register fields use only the low 4 bits
    assign rs1_addr = instr[18:15];
    assign rs2_addr = instr[23:20];
    assign rd_addr  = instr[10:7];

    // In reset the decoder sees BNE x0 x0 so no write or illegal is raised
    assign dec_instr = rst_n ? instr : 32'h0000_1063;

    // Observation strobes
    assign rd_wen    = ctrl_bus.reg_wen;
    assign mem_we    = ctrl_bus.mem_we;
    assign mem_addr  = alu_result;
    assign mem_wdata = rs2_data;

    rv_control u_control (
        .instr   (dec_instr),
        .ctrl    (ctrl_bus.ctrl),
        .illegal (illegal)
    );

    rv_fetch u_fetch (
        .I_clk    (I_clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl_bus.dp),
        .target   (alu_result),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    rv_regfile u_regfile (
        .I_clk      (I_clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl_bus.dp),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rd_addr    (rd_addr),
        .alu_result (alu_result),
        .load_data  (load_data),
        .pc_plus4   (pc_plus4),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .rd_data    (rd_data)
    );

    rv_imm_gen u_imm_gen (
        .instr (instr),
        .ctrl  (ctrl_bus.dp),
        .imm   (imm)
    );

    rv_execute u_execute (
        .ctrl       (ctrl_bus.dp),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .alu_result (alu_result)
    );

    rv_data_mem u_data_mem (
        .I_clk (I_clk),
        .ctrl  (ctrl_bus.dp),
        .addr  (alu_result),
        .wdata (rs2_data),
        .rdata (load_data)
    );

endmodule

`default_nettype wire

// File: rv_data_mem.sv
`include "rv_params.svh"
`default_nettype none

module rv_data_mem (
    input  logic        I_clk,
    rv_ctrl_if.dp       ctrl,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int ADDR_W = $clog2(`RV_DMEM_WORDS);

    logic [31:0]       mem [`RV_DMEM_WORDS];
    logic [ADDR_W-1:0] word_idx;

    // Byte address to word index, upper bits wrap
    assign word_idx = addr[ADDR_W+1:2];

    always_ff @(posedge I_clk) begin
        if (ctrl.mem_we) begin
            mem[word_idx] <= wdata;
        end
    end

    assign rdata = mem[word_idx];

endmodule

`default_nettype wire

// File: rv_execute.sv
`default_nettype none

module rv_execute import rv_pkg::*; (
    rv_ctrl_if.dp       ctrl,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic [31:0] imm,
    output logic [31:0] alu_result
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;

    assign op_a  = ctrl.a_sel ? pc : rs1_data;
    assign op_b  = ctrl.b_sel ? imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SLT:    alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {31'd0, op_a < op_b};
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // Branch comparator always looks at the register values
    assign ctrl.br_eq = rs1_data == rs2_data;
    assign ctrl.br_lt = ctrl.br_un ? (rs1_data < rs2_data)
                                   : ($signed(rs1_data) < $signed(rs2_data));

endmodule

`default_nettype wire

// File: rv_imm_gen.sv
`default_nettype none

module rv_imm_gen import rv_pkg::*; (
    input  instr_t      instr,
    rv_ctrl_if.dp       ctrl,
    output logic [31:0] imm
);

    always_comb begin
        case (ctrl.imm_sel)
            IMM_I: imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            IMM_S: imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            IMM_B: begin
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            IMM_U: imm = {instr.u.imm_31_12, 12'h000};
            IMM_J: begin
                imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rv_regfile.sv
`include "rv_params.svh"
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  logic        I_clk,
    input  logic        rst_n,
    rv_ctrl_if.dp       ctrl,
    input  logic [3:0]  rs1_addr,
    input  logic [3:0]  rs2_addr,
    input  logic [3:0]  rd_addr,
    input  logic [31:0] alu_result,
    input  logic [31:0] load_data,
    input  logic [31:0] pc_plus4,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    output logic [31:0] rd_data
);

    logic [31:0] regs [`RV_REG_COUNT];

    // Write-back source
    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:      rd_data = load_data;
            WB_PC_PLUS4: rd_data = pc_plus4;
            default:     rd_data = alu_result;
        endcase
    end

    always_ff @(posedge I_clk) begin
        if (!rst_n) begin
            for (int k = 0; k < `RV_REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (ctrl.reg_wen && rd_addr != 4'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1_addr == 4'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 4'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: rv_fetch.sv
`include "rv_params.svh"
`default_nettype none

module rv_fetch (
    input  logic        I_clk,
    input  logic        rst_n,
    rv_ctrl_if.dp       ctrl,
    input  logic [31:0] target,
    output logic [31:0] pc,
    output logic [31:0] pc_plus4
);

    logic [31:0] pc_next;

    assign pc_plus4 = pc + 32'd4;

    // Branch and JAL targets are already even, so clearing bit 0 only matters for JALR
    assign pc_next = ctrl.pc_sel ? {target[31:1], 1'b0} : pc_plus4;

    always_ff @(posedge I_clk) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: rv_control.sv
`default_nettype none

module rv_control import rv_pkg::*; (
    input  instr_t    instr,
    rv_ctrl_if.ctrl   ctrl,
    output logic      illegal
);

    // Base ALU op from funct3, alt selects SUB or SRA
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad_enc;
    logic       bad_reg;
    logic       use_rd;
    logic       use_rs1;
    logic       use_rs2;
    logic       taken;

    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;

    // BEQ/BNE pick eq, BLT/BGE/BLTU/BGEU pick lt, funct3[0] inverts
    assign taken = funct3[2] ? (ctrl.br_lt ^ funct3[0]) : (ctrl.br_eq ^ funct3[0]);

    always_comb begin
        ctrl.alu_op  = ALU_ADD;
        ctrl.imm_sel = IMM_I;
        ctrl.a_sel   = 1'b0;
        ctrl.b_sel   = 1'b0;
        ctrl.wb_sel  = WB_ALU;
        ctrl.br_un   = funct3[1];
        bad_enc      = 1'b0;
        use_rd       = 1'b0;
        use_rs1      = 1'b0;
        use_rs2      = 1'b0;
        ctrl.reg_wen = 1'b0;
        ctrl.mem_we  = 1'b0;
        ctrl.pc_sel  = 1'b0;

        case (instr.r.opcode)
            OPC_OP: begin
                {use_rd, use_rs1, use_rs2} = 3'b111;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = alu_from_funct3(funct3, funct7[5]);
                bad_enc = !(funct7 == 7'h00 ||
                            (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                {use_rd, use_rs1} = 2'b11;
                ctrl.reg_wen = 1'b1;
                ctrl.b_sel   = 1'b1;
                // Only SRAI reads the alt bit
                ctrl.alu_op  = alu_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001)
                    bad_enc = funct7 != 7'h00;
                else if (funct3 == 3'b101)
                    bad_enc = funct7 != 7'h00 && funct7 != 7'h20;
            end
            OPC_LUI: begin
                use_rd       = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.imm_sel = IMM_U;
                ctrl.b_sel   = 1'b1;
                ctrl.alu_op  = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                use_rd       = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.imm_sel = IMM_U;
                {ctrl.a_sel, ctrl.b_sel} = 2'b11;
            end
            OPC_LOAD: begin
                {use_rd, use_rs1} = 2'b11;
                ctrl.reg_wen = 1'b1;
                ctrl.b_sel   = 1'b1;
                ctrl.wb_sel  = WB_MEM;
                bad_enc      = funct3 != 3'b010;
            end
            OPC_STORE: begin
                {use_rs1, use_rs2} = 2'b11;
                ctrl.mem_we  = 1'b1;
                ctrl.imm_sel = IMM_S;
                ctrl.b_sel   = 1'b1;
                bad_enc      = funct3 != 3'b010;
            end
            OPC_BRANCH: begin
                {use_rs1, use_rs2} = 2'b11;
                ctrl.imm_sel = IMM_B;
                {ctrl.a_sel, ctrl.b_sel} = 2'b11;
                ctrl.pc_sel  = taken;
                bad_enc      = funct3[2:1] == 2'b01;
            end
            OPC_JAL: begin
                use_rd       = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.imm_sel = IMM_J;
                {ctrl.a_sel, ctrl.b_sel} = 2'b11;
                ctrl.wb_sel  = WB_PC_PLUS4;
                ctrl.pc_sel  = 1'b1;
            end
            OPC_JALR: begin
                {use_rd, use_rs1} = 2'b11;
                ctrl.reg_wen = 1'b1;
                ctrl.b_sel   = 1'b1;
                ctrl.wb_sel  = WB_PC_PLUS4;
                ctrl.pc_sel  = 1'b1;
                bad_enc      = funct3 != 3'b000;
            end
            default: bad_enc = 1'b1;
        endcase

        // x16 and above do not exist in RV32E
        bad_reg = (use_rd && instr.r.rd[4]) || (use_rs1 && instr.r.rs1[4]) ||
                  (use_rs2 && instr.r.rs2[4]);
        illegal = bad_enc || bad_reg;

        // Illegal words retire as a no-op
        if (illegal) begin
            ctrl.reg_wen = 1'b0;
            ctrl.mem_we  = 1'b0;
            ctrl.pc_sel  = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rv_ctrl_if.sv
`default_nettype none

interface rv_ctrl_if;

    logic [3:0] alu_op;
    logic [2:0] imm_sel;
    logic       a_sel;      // 0 rs1, 1 PC
    logic       b_sel;      // 0 rs2, 1 immediate
    logic       reg_wen;
    logic       mem_we;
    logic [1:0] wb_sel;
    logic       pc_sel;     // 0 PC+4, 1 target
    logic       br_un;
    logic       br_eq;
    logic       br_lt;

    // Decoder side
    modport ctrl (
        output alu_op, imm_sel, a_sel, b_sel, reg_wen, mem_we, wb_sel, pc_sel, br_un,
        input  br_eq, br_lt
    );

    // Datapath side, branch flags come back from the comparator
    modport dp (
        input  alu_op, imm_sel, a_sel, b_sel, reg_wen, mem_we, wb_sel, pc_sel, br_un,
        output br_eq, br_lt
    );

endinterface

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Supported major opcodes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC_PLUS4} wb_sel_e;

    // Instruction formats, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One word, six views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

endpackage

`default_nettype wire

// File: rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// RV32E register count, so addresses are 4 bits wide
`define RV_REG_COUNT 16

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 256

// PC after reset
`define RV_RESET_PC 32'h0000_0000

`endif
